//--- rtl/mux_cfg.svh
// Build-time configuration of the write-path multiplexer
// Port count, ID, address and data widths, W routing FIFO depth
`ifndef MUX_CFG_SVH
`define MUX_CFG_SVH

// Number of upstream ports, a power of two of at least 2
`define MUX_NUM_PORTS 4

// Upstream transaction ID width
// The downstream ID is wider by log2 of the port count
`define MUX_SLV_ID_W 3

// Address and data bus widths
`define MUX_ADDR_W 16
`define MUX_DATA_W 16

// AW grants whose W bursts may be outstanding at once
`define MUX_W_FIFO_DEPTH 4

`endif

//--- rtl/mux_route_pkg.sv
// Routing types of the write multiplexer
// Port index and the downstream ID, seen as raw vector or as port plus upstream ID
`include "mux_cfg.svh"

package mux_route_pkg;

  localparam int unsigned PORT_IDX_W = $clog2(`MUX_NUM_PORTS);
  localparam int unsigned MST_ID_W   = `MUX_SLV_ID_W + PORT_IDX_W;

  typedef logic [PORT_IDX_W-1:0]    port_idx_t;
  typedef logic [`MUX_SLV_ID_W-1:0] slv_id_t;

  // Port index sits in the upper bits of the downstream ID
  typedef struct packed {
    port_idx_t port;
    slv_id_t   slv_id;
  } mst_id_fields_t;

  typedef union packed {
    logic [MST_ID_W-1:0] raw;
    mst_id_fields_t      fields;
  } mst_id_t;

endpackage

//--- rtl/axi_chan_pkg.sv
// Channel payload types of the write path
// Upstream and downstream AW and B channels, shared W channel
`include "mux_cfg.svh"

package axi_chan_pkg;

  import mux_route_pkg::*;

  typedef logic [`MUX_ADDR_W-1:0]   addr_t;
  typedef logic [`MUX_DATA_W-1:0]   data_t;
  typedef logic [`MUX_DATA_W/8-1:0] strb_t;
  // Burst length minus one
  typedef logic [3:0]               len_t;

  // ------------------------------------------------------------------
  // Address channels
  // ------------------------------------------------------------------
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_aw_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_aw_t;

  // ------------------------------------------------------------------
  // Data and response channels
  // ------------------------------------------------------------------
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    slv_id_t    id;
    logic [1:0] resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t    id;
    logic [1:0] resp;
  } mst_b_t;

endpackage

//--- rtl/aw_arbiter.sv
// Round-robin AW arbiter with lock-in
// Prepends the granted port index to the AW ID and holds a lock flip-flop
// so that an offered AW stays put without pushing the W FIFO twice
`timescale 1ns/100ps
`include "mux_cfg.svh"

module aw_arbiter (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  axi_chan_pkg::slv_aw_t [`MUX_NUM_PORTS-1:0] slv_aw_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_aw_valid_i,
  output logic                  [`MUX_NUM_PORTS-1:0] slv_aw_ready_o,
  output axi_chan_pkg::mst_aw_t                      mst_aw_o,
  output logic                                       mst_aw_valid_o,
  input  logic                                       mst_aw_ready_i,
  input  logic                                       fifo_full_i,
  output logic                                       grant_push_o,
  output mux_route_pkg::port_idx_t                   grant_port_o
);

  import mux_route_pkg::*;

  // Port with the highest priority in the next decision
  port_idx_t rr_ptr_q;
  port_idx_t rr_ptr_d;

  // Offered AW still waiting for downstream ready
  logic      lock_q;
  logic      lock_d;
  port_idx_t lock_port_q;

  port_idx_t arb_port;
  port_idx_t cand_port;
  port_idx_t cur_port;
  logic      arb_found;
  logic      aw_accept;
  mst_id_t   aw_id;

  // ------------------------------------------------------------------
  // Port selection
  // ------------------------------------------------------------------
  // Scan from the pointer upward, wrapping through the index width
  always_comb begin
    arb_found = 1'b0;
    arb_port  = rr_ptr_q;
    cand_port = rr_ptr_q;
    for (int unsigned i = 0; i < `MUX_NUM_PORTS; i++) begin
      cand_port = port_idx_t'(rr_ptr_q + i);
      if (!arb_found && slv_aw_valid_i[cand_port]) begin
        arb_found = 1'b1;
        arb_port  = cand_port;
      end
    end
  end

  // A locked grant wins over any new decision
  assign cur_port = lock_q ? lock_port_q : arb_port;

  // ------------------------------------------------------------------
  // Handshake and lock control
  // ------------------------------------------------------------------
  always_comb begin
    lock_d         = lock_q;
    mst_aw_valid_o = 1'b0;
    grant_push_o   = 1'b0;
    slv_aw_ready_o = '0;
    if (lock_q) begin
      mst_aw_valid_o = 1'b1;
      if (mst_aw_ready_i) begin
        slv_aw_ready_o[cur_port] = 1'b1;
        lock_d                   = 1'b0;
      end
    end else if (arb_found && !fifo_full_i) begin
      // First cycle on the bus, so the grant goes into the W FIFO now
      mst_aw_valid_o = 1'b1;
      grant_push_o   = 1'b1;
      if (mst_aw_ready_i) begin
        slv_aw_ready_o[cur_port] = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  assign aw_accept    = mst_aw_valid_o && mst_aw_ready_i;
  assign rr_ptr_d     = aw_accept ? port_idx_t'(cur_port + 1'b1) : rr_ptr_q;
  assign grant_port_o = arb_port;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q    <= '0;
      lock_q      <= 1'b0;
      lock_port_q <= '0;
    end else begin
      rr_ptr_q <= rr_ptr_d;
      lock_q   <= lock_d;
      if (grant_push_o) begin
        lock_port_q <= arb_port;
      end
    end
  end

  // ------------------------------------------------------------------
  // ID prepend
  // ------------------------------------------------------------------
  always_comb begin
    aw_id.fields.port   = cur_port;
    aw_id.fields.slv_id = slv_aw_i[cur_port].id;
  end

  assign mst_aw_o = '{id:   aw_id,
                      addr: slv_aw_i[cur_port].addr,
                      len:  slv_aw_i[cur_port].len};

endmodule

//--- rtl/w_route_fifo.sv
// W burst router
// Circular FIFO of granted port indices, the head steers one upstream
// W stream to the downstream port until its last beat
`timescale 1ns/100ps
`include "mux_cfg.svh"

module w_route_fifo (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       push_i,
  input  mux_route_pkg::port_idx_t                   port_i,
  output logic                                       full_o,
  input  axi_chan_pkg::w_chan_t [`MUX_NUM_PORTS-1:0] slv_w_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_w_valid_i,
  output logic                  [`MUX_NUM_PORTS-1:0] slv_w_ready_o,
  output axi_chan_pkg::w_chan_t                      mst_w_o,
  output logic                                       mst_w_valid_o,
  input  logic                                       mst_w_ready_i
);

  import mux_route_pkg::*;

  localparam int unsigned DEPTH = `MUX_W_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  port_idx_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty;
  logic             pop;
  port_idx_t        head;

  // Pointer advance with wrap at any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------------------------------------------
  // Grant FIFO
  // ------------------------------------------------------------------
  assign empty  = (count_q == '0);
  assign full_o = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= port_i;
    end
  end

  // ------------------------------------------------------------------
  // W steering
  // ------------------------------------------------------------------
  assign head          = mem_q[rd_ptr_q];
  assign mst_w_o       = slv_w_i[head];
  assign mst_w_valid_o = !empty && slv_w_valid_i[head];

  always_comb begin
    slv_w_ready_o       = '0;
    slv_w_ready_o[head] = !empty && mst_w_ready_i;
  end

  // Burst ends here, next grant takes over
  assign pop = mst_w_valid_o && mst_w_ready_i && mst_w_o.last;

endmodule

//--- rtl/ace_write_mux.sv
// Write-path multiplexer top level
// AW arbitration, W routing by grant order, B routing by ID prefix
`timescale 1ns/100ps
`include "mux_cfg.svh"

module ace_write_mux (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Upstream ports
  input  axi_chan_pkg::slv_aw_t [`MUX_NUM_PORTS-1:0] slv_aw_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_aw_valid_i,
  output logic                  [`MUX_NUM_PORTS-1:0] slv_aw_ready_o,
  input  axi_chan_pkg::w_chan_t [`MUX_NUM_PORTS-1:0] slv_w_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_w_valid_i,
  output logic                  [`MUX_NUM_PORTS-1:0] slv_w_ready_o,
  output axi_chan_pkg::slv_b_t  [`MUX_NUM_PORTS-1:0] slv_b_o,
  output logic                  [`MUX_NUM_PORTS-1:0] slv_b_valid_o,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_b_ready_i,
  // Downstream port
  output axi_chan_pkg::mst_aw_t                      mst_aw_o,
  output logic                                       mst_aw_valid_o,
  input  logic                                       mst_aw_ready_i,
  output axi_chan_pkg::w_chan_t                      mst_w_o,
  output logic                                       mst_w_valid_o,
  input  logic                                       mst_w_ready_i,
  input  axi_chan_pkg::mst_b_t                       mst_b_i,
  input  logic                                       mst_b_valid_i,
  output logic                                       mst_b_ready_o
);

  import mux_route_pkg::*;

  logic      grant_push;
  port_idx_t grant_port;
  logic      fifo_full;
  mst_id_t   b_id;
  port_idx_t b_port;

  aw_arbiter aw_arbiter_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .slv_aw_i       ( slv_aw_i       ),
    .slv_aw_valid_i ( slv_aw_valid_i ),
    .slv_aw_ready_o ( slv_aw_ready_o ),
    .mst_aw_o       ( mst_aw_o       ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .fifo_full_i    ( fifo_full      ),
    .grant_push_o   ( grant_push     ),
    .grant_port_o   ( grant_port     )
  );

  w_route_fifo w_route_fifo_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .push_i        ( grant_push    ),
    .port_i        ( grant_port    ),
    .full_o        ( fifo_full     ),
    .slv_w_i       ( slv_w_i       ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_o       ( mst_w_o       ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  // ------------------------------------------------------------------
  // B routing
  // ------------------------------------------------------------------
  assign b_id   = mst_b_i.id;
  assign b_port = b_id.fields.port;

  // Same stripped response on every port, only one sees valid
  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_b_strip
    assign slv_b_o[i] = '{id: b_id.fields.slv_id, resp: mst_b_i.resp};
  end

  always_comb begin
    slv_b_valid_o         = '0;
    slv_b_valid_o[b_port] = mst_b_valid_i;
  end

  assign mst_b_ready_o = mst_b_valid_i && slv_b_ready_i[b_port];

endmodule

//--- verification/mux_checker.sv
// Reference model and compare process of the write-path multiplexer
// Checks ID prepend, round-robin order, W order and data, FIFO limit and B routing
`timescale 1ns/100ps
`include "mux_cfg.svh"

module mux_checker (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  axi_chan_pkg::slv_aw_t [`MUX_NUM_PORTS-1:0] slv_aw_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_aw_valid_i,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_aw_ready_o,
  input  axi_chan_pkg::mst_aw_t                      mst_aw_o,
  input  logic                                       mst_aw_valid_o,
  input  logic                                       mst_aw_ready_i,
  input  axi_chan_pkg::w_chan_t                      mst_w_o,
  input  logic                                       mst_w_valid_o,
  input  logic                                       mst_w_ready_i,
  input  axi_chan_pkg::slv_b_t  [`MUX_NUM_PORTS-1:0] slv_b_o,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_b_valid_o,
  input  logic                  [`MUX_NUM_PORTS-1:0] slv_b_ready_i,
  input  axi_chan_pkg::mst_b_t                       mst_b_i,
  input  logic                                       mst_b_valid_i,
  input  logic                                       mst_b_ready_o,
  output int unsigned                                mismatch_cnt_o
);

  import axi_chan_pkg::*;
  import mux_route_pkg::*;

  localparam int unsigned N = `MUX_NUM_PORTS;

  slv_aw_t     issued_q [N][$];
  port_idx_t   order_port_q[$];
  len_t        order_len_q[$];
  int unsigned serial [N];
  int unsigned beat;
  int unsigned outstanding;
  int unsigned errs = 0;
  port_idx_t   rr_next;
  logic        aw_wait;
  port_idx_t   p_exp;
  port_idx_t   hp;
  mst_aw_t     aw_exp;
  w_chan_t     w_exp;
  slv_b_t      b_exp;
  logic [N-1:0] bv_exp;

  assign mismatch_cnt_o = errs;

  // First requesting port at or after the start index
  function automatic port_idx_t rr_pick(input port_idx_t start, input logic [N-1:0] req);
    port_idx_t p;
    port_idx_t pick;
    pick = start;
    for (int i = N - 1; i >= 0; i--) begin
      p = port_idx_t'(start + i);
      if (req[p]) begin
        pick = p;
      end
    end
    return pick;
  endfunction

  function automatic mst_aw_t aw_prepend(input port_idx_t port, input slv_aw_t aw);
    mst_aw_t r;
    r.id.raw = {port, aw.id};
    r.addr   = aw.addr;
    r.len    = aw.len;
    return r;
  endfunction

  // Beat data carries port, burst serial and beat number
  function automatic w_chan_t w_beat(input port_idx_t port, input int unsigned ser,
                                     input int unsigned bt, input len_t len);
    w_chan_t w;
    w.data = {4'(port), 8'(ser), 4'(bt)};
    w.strb = '1;
    w.last = (bt == int'(len));
    return w;
  endfunction

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rr_next     = '0;
      aw_wait     = 1'b0;
      beat        = 0;
      outstanding = 0;
    end else begin
      for (int p = 0; p < N; p++) begin
        if (slv_aw_valid_i[p] && slv_aw_ready_o[p]) begin
          issued_q[p].push_back(slv_aw_i[p]);
        end
      end
      // ------------------------------------------------------------------
      // AW offer, arbitration and ID prepend
      // ------------------------------------------------------------------
      if (mst_aw_valid_o && !aw_wait) begin
        p_exp = rr_pick(rr_next, slv_aw_valid_i);
        if (mst_aw_o.id.fields.port != p_exp) begin
          $display("mismatch mst_aw_o.id.port: got %h expected %h",
                   mst_aw_o.id.fields.port, p_exp);
          errs++;
        end
        if (outstanding >= `MUX_W_FIFO_DEPTH) begin
          $display("error: AW offered while %0d W bursts were outstanding", outstanding);
          errs++;
        end
        order_port_q.push_back(mst_aw_o.id.fields.port);
        order_len_q.push_back(mst_aw_o.len);
        outstanding++;
      end
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        hp = mst_aw_o.id.fields.port;
        if (issued_q[hp].size() == 0) begin
          $display("error: downstream AW for port %0d that never issued one", hp);
          errs++;
        end else begin
          aw_exp = aw_prepend(hp, issued_q[hp].pop_front());
          if (mst_aw_o != aw_exp) begin
            $display("mismatch mst_aw_o: got %h expected %h", mst_aw_o, aw_exp);
            errs++;
          end
        end
        rr_next = port_idx_t'(hp + 1'b1);
      end
      aw_wait = mst_aw_valid_o && !mst_aw_ready_i;
      // ------------------------------------------------------------------
      // W order and data
      // ------------------------------------------------------------------
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (order_port_q.size() == 0) begin
          $display("error: W beat passed with no AW offered for it");
          errs++;
        end else begin
          hp    = order_port_q[0];
          w_exp = w_beat(hp, serial[hp], beat, order_len_q[0]);
          if (mst_w_o != w_exp) begin
            $display("mismatch mst_w_o: got %h expected %h", mst_w_o, w_exp);
            errs++;
          end
          beat++;
          if (w_exp.last) begin
            void'(order_port_q.pop_front());
            void'(order_len_q.pop_front());
            serial[hp]++;
            beat = 0;
            outstanding--;
          end
        end
      end
      // B routing by the upper ID bits
      if (mst_b_valid_i) begin
        hp         = port_idx_t'(mst_b_i.id.raw >> `MUX_SLV_ID_W);
        bv_exp     = '0;
        bv_exp[hp] = 1'b1;
        b_exp.id   = slv_id_t'(mst_b_i.id.raw);
        b_exp.resp = mst_b_i.resp;
        if (slv_b_valid_o != bv_exp) begin
          $display("mismatch slv_b_valid_o: got %h expected %h", slv_b_valid_o, bv_exp);
          errs++;
        end
        if (slv_b_o[hp] != b_exp) begin
          $display("mismatch slv_b_o: got %h expected %h", slv_b_o[hp], b_exp);
          errs++;
        end
        // Downstream ready follows the addressed port only
        if (mst_b_ready_o != slv_b_ready_i[hp]) begin
          $display("mismatch mst_b_ready_o: got %h expected %h",
                   mst_b_ready_o, slv_b_ready_i[hp]);
          errs++;
        end
      end
    end
  end

endmodule

//--- verification/mux_properties.sv
// Bound assertions for the write-path multiplexer
// Downstream AW and W stability, B valid exclusivity, valids in reset
`timescale 1ns/100ps
`include "mux_cfg.svh"

module mux_properties (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input axi_chan_pkg::mst_aw_t                 mst_aw_o,
  input logic                                  mst_aw_valid_o,
  input logic                                  mst_aw_ready_i,
  input axi_chan_pkg::w_chan_t                 mst_w_o,
  input logic                                  mst_w_valid_o,
  input logic                                  mst_w_ready_i,
  input logic             [`MUX_NUM_PORTS-1:0] slv_b_valid_o,
  input logic                                  mst_b_ready_o
);

  // An offered AW stays put until downstream takes it
  aw_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o))
    else $error("downstream AW changed before ready");

  w_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_o))
    else $error("downstream W changed before ready");

  b_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(slv_b_valid_o))
    else $error("more than one upstream B valid");

  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_ni |-> !mst_aw_valid_o && !mst_w_valid_o && slv_b_valid_o == '0 && !mst_b_ready_o)
    else $error("valid or ready high during reset");

endmodule

bind ace_write_mux mux_properties mux_properties_inst (.*);

//--- verification/tb_ace_write_mux.sv
// Testbench of the write-path multiplexer
// Clock, reset, random AW and W traffic per port, downstream responder with W stall
`timescale 1ns/100ps
`include "mux_cfg.svh"

module tb_ace_write_mux;

  import axi_chan_pkg::*;
  import mux_route_pkg::*;

  localparam int unsigned N           = `MUX_NUM_PORTS;
  localparam int unsigned TXN         = 24;
  localparam int unsigned TOTAL       = N * TXN;
  localparam int unsigned WAIT_LIMIT  = 2000;
  localparam int unsigned STALL_START = 150;
  localparam int unsigned STALL_LEN   = 80;

  logic                clk_i;
  logic                rst_ni;
  slv_aw_t [N-1:0]     slv_aw;
  logic    [N-1:0]     slv_aw_valid;
  logic    [N-1:0]     slv_aw_ready;
  w_chan_t [N-1:0]     slv_w;
  logic    [N-1:0]     slv_w_valid;
  logic    [N-1:0]     slv_w_ready;
  slv_b_t  [N-1:0]     slv_b;
  logic    [N-1:0]     slv_b_valid;
  logic    [N-1:0]     slv_b_ready;
  mst_aw_t             mst_aw;
  logic                mst_aw_valid;
  logic                mst_aw_ready;
  w_chan_t             mst_w;
  logic                mst_w_valid;
  logic                mst_w_ready;
  mst_b_t              mst_b;
  logic                mst_b_valid;
  logic                mst_b_ready;

  int unsigned cycle = 0;
  int unsigned timeout_cnt = 0;
  int unsigned mismatch_cnt;
  int unsigned b_done = 0;
  logic        aw_wait;
  len_t        w_len_q [N][$];
  mst_id_t     aw_ids[$];
  mst_id_t     b_pending[$];

  ace_write_mux ace_write_mux_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i (slv_w), .slv_w_valid_i (slv_w_valid), .slv_w_ready_o (slv_w_ready),
    .slv_b_o (slv_b), .slv_b_valid_o (slv_b_valid), .slv_b_ready_i (slv_b_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready)
  );

  mux_checker mux_checker_inst (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o (mst_w), .mst_w_valid_o (mst_w_valid), .mst_w_ready_i (mst_w_ready),
    .slv_b_o (slv_b), .slv_b_valid_o (slv_b_valid), .slv_b_ready_i (slv_b_ready),
    .mst_b_i (mst_b), .mst_b_valid_i (mst_b_valid), .mst_b_ready_o (mst_b_ready),
    .mismatch_cnt_o (mismatch_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic bit ready_seen(input int unsigned kind, input int unsigned p);
    case (kind)
      0:       return slv_aw_ready[p];
      1:       return slv_w_ready[p];
      default: return mst_b_ready;
    endcase
  endfunction

  // Ends on the edge where the transfer happens
  task automatic await_ready(input int unsigned kind, input int unsigned p, output bit ok);
    int unsigned n;
    n  = 0;
    ok = 1'b1;
    @(negedge clk_i);
    while (!ready_seen(kind, p)) begin
      if (n == WAIT_LIMIT) begin
        $display("error: handshake of kind %0d on port %0d timed out", kind, p);
        timeout_cnt++;
        ok = 1'b0;
        return;
      end
      n++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  // ------------------------------------------------------------------
  // Upstream traffic
  // ------------------------------------------------------------------
  task automatic issue_aws(input int unsigned p);
    slv_aw_t aw;
    bit      ok;
    for (int unsigned t = 0; t < TXN; t++) begin
      repeat ($urandom_range(0, 3)) @(posedge clk_i);
      aw.id   = slv_id_t'($urandom);
      aw.addr = addr_t'($urandom);
      aw.len  = len_t'($urandom_range(0, 3));
      #1;
      slv_aw[p]       = aw;
      slv_aw_valid[p] = 1'b1;
      await_ready(0, p, ok);
      #1;
      slv_aw_valid[p] = 1'b0;
      if (!ok) return;
      w_len_q[p].push_back(aw.len);
    end
  endtask

  task automatic send_bursts(input int unsigned p);
    w_chan_t     w;
    len_t        len;
    bit          ok;
    int unsigned n;
    for (int unsigned t = 0; t < TXN; t++) begin
      n = 0;
      while (w_len_q[p].size() == 0) begin
        if (n == WAIT_LIMIT) begin
          $display("error: port %0d saw no accepted AW for its next burst", p);
          timeout_cnt++;
          return;
        end
        n++;
        @(posedge clk_i);
      end
      len = w_len_q[p].pop_front();
      for (int unsigned bt = 0; bt <= int'(len); bt++) begin
        w.data = {4'(p), 8'(t), 4'(bt)};
        w.strb = '1;
        w.last = (bt == int'(len));
        #1;
        slv_w[p]       = w;
        slv_w_valid[p] = 1'b1;
        await_ready(1, p, ok);
        if (!ok) return;
      end
      #1;
      slv_w_valid[p] = 1'b0;
    end
  endtask

  // ------------------------------------------------------------------
  // Downstream responder
  // ------------------------------------------------------------------
  initial begin
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    slv_b_ready  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      cycle++;
      mst_aw_ready = ($urandom_range(0, 3) != 0);
      // W held off for a window so the grant FIFO fills
      if (cycle >= STALL_START && cycle < STALL_START + STALL_LEN) begin
        mst_w_ready = 1'b0;
      end else begin
        mst_w_ready = ($urandom_range(0, 3) != 0);
      end
      slv_b_ready = N'($urandom);
    end
  end

  // IDs queue up in offer order, which is also W order
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      aw_wait = 1'b0;
    end else begin
      if (mst_aw_valid && !aw_wait) begin
        aw_ids.push_back(mst_aw.id);
      end
      aw_wait = mst_aw_valid && !mst_aw_ready;
      if (mst_w_valid && mst_w_ready && mst_w.last && aw_ids.size() > 0) begin
        b_pending.push_back(aw_ids.pop_front());
      end
    end
  end

  initial begin
    bit ok;
    mst_b       = '0;
    mst_b_valid = 1'b0;
    forever begin
      @(posedge clk_i);
      if (b_pending.size() > 0) begin
        repeat ($urandom_range(0, 4)) @(posedge clk_i);
        #1;
        mst_b.id    = b_pending.pop_front();
        mst_b.resp  = 2'($urandom);
        mst_b_valid = 1'b1;
        await_ready(2, 0, ok);
        if (ok) begin
          b_done++;
        end
        #1;
        mst_b_valid = 1'b0;
      end
    end
  end

  task automatic finish_run();
    $display("checks done: mismatches=%0d timeouts=%0d", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    int unsigned n;
    void'($urandom(32'h6547));
    rst_ni       = 1'b0;
    slv_aw       = '0;
    slv_aw_valid = '0;
    slv_w        = '0;
    slv_w_valid  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fork
      issue_aws(0);
      issue_aws(1);
      issue_aws(2);
      issue_aws(3);
      send_bursts(0);
      send_bursts(1);
      send_bursts(2);
      send_bursts(3);
    join
    n = 0;
    while (b_done < TOTAL && n < WAIT_LIMIT) begin
      n++;
      @(posedge clk_i);
    end
    if (b_done < TOTAL) begin
      $display("error: only %0d of %0d B responses completed", b_done, TOTAL);
      timeout_cnt++;
    end
    repeat (5) @(posedge clk_i);
    finish_run();
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/mux_route_pkg.sv
rtl/axi_chan_pkg.sv
rtl/aw_arbiter.sv
rtl/w_route_fifo.sv
rtl/ace_write_mux.sv
verification/mux_checker.sv
verification/mux_properties.sv
verification/tb_ace_write_mux.sv

//--- Makefile
# Verilator build and run of the write-path multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_ace_write_mux
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
